/* common/pcxt_timing_pkg.sv */
/*
 * Shared constants and types for the PC/XT timing front end.
 * All rates assume a 50 MHz reference on CLK_50M.
 * ACC_WIDTH must hold CLK_HZ plus the largest tick rate.
 */
`default_nettype none

package pcxt_timing_pkg;

	//////////////////////////////////////////////////////////////////////
	// Clocking
	//////////////////////////////////////////////////////////////////////

	// Reference clock in Hz
	localparam logic [31:0] CLK_HZ = 32'd50_000_000;

	// 2^27 is above 50 MHz + 14.318 MHz
	localparam int ACC_WIDTH = 27;

	// Enable channels, one accumulator each
	localparam int NUM_TICKS = 5;

	typedef enum logic [2:0] {
		TICK_4M77   = 3'd0,
		TICK_7M16   = 3'd1,
		TICK_14M3   = 3'd2,
		TICK_PERIPH = 3'd3,
		TICK_AUDIO  = 3'd4
	} tick_id_e;

	// Average rate per channel, indexed by tick_id_e
	localparam logic [31:0] TICK_RATE_HZ [NUM_TICKS] = '{
		32'd4_772_727,
		32'd7_159_090,
		32'd14_318_181,
		32'd2_386_363,
		32'd44_100
	};

	//////////////////////////////////////////////////////////////////////
	// Reset sequencing
	//////////////////////////////////////////////////////////////////////

	// Edges of sys_reset after reset_wire release
	localparam int unsigned SYS_RESET_CYCLES = 65_536;
	// Extra edges of cpu_reset after sys_reset release
	localparam int unsigned CPU_RESET_CYCLES = 43;
	localparam int RESET_COUNT_WIDTH = 17;

	// Code 3 is unused, treated as 4.77 MHz
	typedef enum logic [1:0] {
		SPEED_4M77 = 2'd0,
		SPEED_7M16 = 2'd1,
		SPEED_14M3 = 2'd2
	} cpu_speed_e;

	// One bit flips per step, bit 1 is sys_reset, bit 0 is cpu_reset
	typedef enum logic [1:0] {
		RST_SYS = 2'b11,
		RST_CPU = 2'b01,
		RST_RUN = 2'b00
	} reset_state_e;

endpackage

`default_nettype wire

/* common/tick_if.sv */
/*
 * System reset and tick enables shared inside the timing block.
 * Each tick bit has exactly one driver, its own rate_strobe.
 */
`timescale 1ns/1ps
`default_nettype none

interface tick_if;

	// Level, high from reset_wire until the stretch ends
	logic sys_reset;

	// One-cycle enables, bit index is tick_id_e
	wire [pcxt_timing_pkg::NUM_TICKS-1:0] tick;

	// Reset sequencer side
	modport seq (output sys_reset);

	// Accumulator channel side, drives only its own bit
	modport gen (input sys_reset, output tick);

	// Speed select side
	modport sel (input sys_reset, input tick);

endinterface

`default_nettype wire

/* source/reset_sequencer.sv */
/*
 * Stretches the system reset and holds the processor reset longer.
 * reset_wire is asynchronous and restarts the whole sequence.
 * sys_reset drops SYS_RESET_CYCLES edges after reset_wire falls,
 * cpu_reset CPU_RESET_CYCLES edges after that.
 */
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer (
	input  wire  CLK_50M,
	input  wire  reset_wire,
	tick_if.seq  tick_bus,
	output logic cpu_reset
);

	typedef logic [pcxt_timing_pkg::RESET_COUNT_WIDTH-1:0] count_t;

	pcxt_timing_pkg::reset_state_e state;
	count_t                        count;
	logic                          count_last;

	// Last edge of the current phase
	assign count_last = (count == count_t'(1));

	//////////////////////////////////////////////////////////////////////
	// Phase FSM with one shared down counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			state <= pcxt_timing_pkg::RST_SYS;
			count <= count_t'(pcxt_timing_pkg::SYS_RESET_CYCLES);
		end else begin
			case (state)
				pcxt_timing_pkg::RST_SYS: begin
					if (count_last) begin
						// System reset ends on this edge
						state <= pcxt_timing_pkg::RST_CPU;
						count <= count_t'(pcxt_timing_pkg::CPU_RESET_CYCLES);
					end else begin
						count <= count - count_t'(1);
					end
				end
				pcxt_timing_pkg::RST_CPU: begin
					if (count_last) begin
						state <= pcxt_timing_pkg::RST_RUN;
					end else begin
						count <= count - count_t'(1);
					end
				end
				pcxt_timing_pkg::RST_RUN: begin
					// Stay here until the next reset_wire
					state <= pcxt_timing_pkg::RST_RUN;
				end
				default: begin
					// Stray code, start over
					state <= pcxt_timing_pkg::RST_SYS;
					count <= count_t'(pcxt_timing_pkg::SYS_RESET_CYCLES);
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reset levels decoded from the state
	//////////////////////////////////////////////////////////////////////

	// Async high with reset_wire through the state reset
	assign tick_bus.sys_reset = (state == pcxt_timing_pkg::RST_SYS);
	// High in both reset phases
	assign cpu_reset = (state != pcxt_timing_pkg::RST_RUN);

endmodule

`default_nettype wire

/* clocking/rate_strobe.sv */
/*
 * Running-sum clock enable at TICK_RATE_HZ[TICK_INDEX].
 * Tick gap is floor or ceil of CLK_HZ / rate, jitter one cycle.
 * TICK_INDEX must be below NUM_TICKS.
 */
`timescale 1ns/1ps
`default_nettype none

module rate_strobe #(
	parameter int TICK_INDEX = 0
) (
	input  wire CLK_50M,
	input  wire reset_wire,
	tick_if.gen tick_bus
);

	typedef logic [pcxt_timing_pkg::ACC_WIDTH-1:0] acc_t;

	acc_t acc;
	acc_t acc_sum;
	logic tick_q;

	// Next sum, never wraps with ACC_WIDTH bits
	assign acc_sum = acc + acc_t'(pcxt_timing_pkg::TICK_RATE_HZ[TICK_INDEX]);

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			acc    <= '0;
			tick_q <= 1'b0;
		end else if (tick_bus.sys_reset) begin
			// Held clear through the stretched reset
			acc    <= '0;
			tick_q <= 1'b0;
		end else if (acc_sum >= acc_t'(pcxt_timing_pkg::CLK_HZ)) begin
			// Crossed one clock period of credit
			acc    <= acc_sum - acc_t'(pcxt_timing_pkg::CLK_HZ);
			tick_q <= 1'b1;
		end else begin
			acc    <= acc_sum;
			tick_q <= 1'b0;
		end
	end

	// Own bit of the shared tick vector
	assign tick_bus.tick[TICK_INDEX] = tick_q;

endmodule

`default_nettype wire

/* clocking/cpu_clock_select.sv */
/*
 * Active processor speed, taken from speed_request only on bus_done.
 * New speed shows one cycle after the bus_done edge.
 * Code 3 falls back to 4.77 MHz. Tick outputs add no latency.
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_clock_select (
	input  wire                              CLK_50M,
	input  wire                              reset_wire,
	tick_if.sel                              tick_bus,
	input  wire pcxt_timing_pkg::cpu_speed_e speed_request,
	input  wire                              bus_done,
	output pcxt_timing_pkg::cpu_speed_e      cpu_speed,
	output logic                             cpu_tick,
	output logic                             periph_tick,
	output logic                             audio_tick,
	output logic                             turbo
);

	//////////////////////////////////////////////////////////////////////
	// Speed register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_speed <= pcxt_timing_pkg::SPEED_4M77;
		end else if (tick_bus.sys_reset) begin
			cpu_speed <= pcxt_timing_pkg::SPEED_4M77;
		end else if (bus_done) begin
			// Switch only between bus cycles
			case (speed_request)
				pcxt_timing_pkg::SPEED_7M16,
				pcxt_timing_pkg::SPEED_14M3: cpu_speed <= speed_request;
				default:                     cpu_speed <= pcxt_timing_pkg::SPEED_4M77;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Tick routing
	//////////////////////////////////////////////////////////////////////

	// Processor enable follows the active speed
	always_comb begin
		case (cpu_speed)
			pcxt_timing_pkg::SPEED_7M16: begin
				cpu_tick = tick_bus.tick[pcxt_timing_pkg::TICK_7M16];
			end
			pcxt_timing_pkg::SPEED_14M3: begin
				cpu_tick = tick_bus.tick[pcxt_timing_pkg::TICK_14M3];
			end
			default: begin
				cpu_tick = tick_bus.tick[pcxt_timing_pkg::TICK_4M77];
			end
		endcase
	end

	// Fixed-rate enables pass straight through
	assign periph_tick = tick_bus.tick[pcxt_timing_pkg::TICK_PERIPH];
	assign audio_tick  = tick_bus.tick[pcxt_timing_pkg::TICK_AUDIO];

	// Anything above stock XT speed
	assign turbo = (cpu_speed != pcxt_timing_pkg::SPEED_4M77);

endmodule

`default_nettype wire

/* source/pcxt_timing_top.sv */
/*
 * Timing and reset front end of the PC/XT core, all on CLK_50M.
 * Ticks are one-cycle enables, not clocks.
 * reset_wire is asynchronous, active high.
 */
`timescale 1ns/1ps
`default_nettype none

module pcxt_timing_top (
	input  wire                              CLK_50M,
	input  wire                              reset_wire,
	input  wire pcxt_timing_pkg::cpu_speed_e speed_request,
	input  wire                              bus_done,
	output wire                              sys_reset,
	output wire                              cpu_reset,
	output wire                              cpu_tick,
	output wire                              periph_tick,
	output wire                              audio_tick,
	output wire pcxt_timing_pkg::cpu_speed_e cpu_speed,
	output wire                              turbo
);

	// Reset level and tick lines between the blocks
	tick_if tick_bus ();

	//////////////////////////////////////////////////////////////////////
	// Reset stretch and processor reset delay
	//////////////////////////////////////////////////////////////////////

	reset_sequencer reset_sequencer_inst (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.tick_bus   (tick_bus.seq),
		.cpu_reset  (cpu_reset)
	);

	assign sys_reset = tick_bus.sys_reset;

	//////////////////////////////////////////////////////////////////////
	// Fractional enables, one channel per tick_id_e
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < pcxt_timing_pkg::NUM_TICKS; i++) begin : gen_strobe
		rate_strobe #(
			.TICK_INDEX (i)
		) rate_strobe_inst (
			.CLK_50M    (CLK_50M),
			.reset_wire (reset_wire),
			.tick_bus   (tick_bus.gen)
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Speed select and tick outputs
	//////////////////////////////////////////////////////////////////////

	cpu_clock_select cpu_clock_select_inst (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.tick_bus      (tick_bus.sel),
		.speed_request (speed_request),
		.bus_done      (bus_done),
		.cpu_speed     (cpu_speed),
		.cpu_tick      (cpu_tick),
		.periph_tick   (periph_tick),
		.audio_tick    (audio_tick),
		.turbo         (turbo)
	);

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
/*
 * Testbench clock and power-on reset.
 * 20 ns clock period, reset high for the first 8 rising edges.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic CLK_50M,
	output logic power_on_reset
);

	// Free-running 50 MHz clock
	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	// Released on a rising edge like any other stimulus
	initial begin
		power_on_reset = 1'b1;
		repeat (8) @(posedge CLK_50M);
		power_on_reset <= 1'b0;
	end

endmodule

`default_nettype wire

/* test/pcxt_timing_assert.sv */
/*
 * Concurrent properties bound onto the timing top level.
 * Tick and speed properties are off while reset_wire is high.
 */
`timescale 1ns/1ps
`default_nettype none

module pcxt_timing_assert (
	input wire                              CLK_50M,
	input wire                              reset_wire,
	input wire                              bus_done,
	input wire                              sys_reset,
	input wire                              cpu_reset,
	input wire                              audio_tick,
	input wire pcxt_timing_pkg::cpu_speed_e cpu_speed
);

	//////////////////////////////////////////////////////////////////////
	// Reset ordering
	//////////////////////////////////////////////////////////////////////

	// Processor stays in reset while the system is, and one edge past it
	sys_holds_cpu: assert property (@(posedge CLK_50M)
		sys_reset |-> cpu_reset ##1 cpu_reset)
		else $error("cpu_reset low during or right after sys_reset");

	//////////////////////////////////////////////////////////////////////
	// Enables and speed
	//////////////////////////////////////////////////////////////////////

	// Audio enable is a single-cycle pulse
	audio_one_cycle: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		audio_tick |=> !audio_tick)
		else $error("audio_tick high for two cycles in a row");

	// Speed moves only one cycle after a bus_done
	speed_on_bus_done: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		!$stable(cpu_speed) |-> $past(bus_done))
		else $error("cpu_speed changed without a bus_done in the cycle before");

endmodule

bind pcxt_timing_top pcxt_timing_assert pcxt_timing_assert_inst (.*);

`default_nettype wire

/* test/pcxt_timing_tb.sv */
/*
 * Random-stimulus testbench for the timing and reset front end.
 * Runs two reset sequences, the second from a mid-run reset_wire pulse.
 * Stops at the first mismatch against the model. About 171k cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module pcxt_timing_tb;

	localparam int unsigned SYS_CYCLES   = pcxt_timing_pkg::SYS_RESET_CYCLES;
	localparam int unsigned CPU_CYCLES   = pcxt_timing_pkg::CPU_RESET_CYCLES;
	localparam int unsigned STIM_CYCLES  = 20_000;
	localparam int unsigned PULSE_CYCLES = 3;
	// Both reset sequences plus traffic, then 20 percent margin
	localparam int unsigned RUN_CYCLES =
		8 + PULSE_CYCLES + 2 * (SYS_CYCLES + CPU_CYCLES + STIM_CYCLES);
	localparam int unsigned TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 5;
	localparam logic [31:0] PERIPH_RATE =
		pcxt_timing_pkg::TICK_RATE_HZ[pcxt_timing_pkg::TICK_PERIPH];
	localparam logic [31:0] AUDIO_RATE =
		pcxt_timing_pkg::TICK_RATE_HZ[pcxt_timing_pkg::TICK_AUDIO];

	wire  CLK_50M;
	wire  power_on_reset;
	wire  reset_wire;
	logic pulse_reset = 1'b0;
	logic bus_done = 1'b0;
	pcxt_timing_pkg::cpu_speed_e speed_request = pcxt_timing_pkg::SPEED_4M77;
	wire  sys_reset;
	wire  cpu_reset;
	wire  cpu_tick;
	wire  periph_tick;
	wire  audio_tick;
	wire  turbo;
	wire  pcxt_timing_pkg::cpu_speed_e cpu_speed;

	integer seed = 32'h0b12_6553;

	// Model state
	int unsigned sys_count;
	int unsigned cpu_count;
	logic        model_sys;
	logic        model_cpu;
	pcxt_timing_pkg::cpu_speed_e model_speed;
	pcxt_timing_pkg::cpu_speed_e prev_speed = pcxt_timing_pkg::SPEED_4M77;

	// Interval tracking
	int unsigned cycle = 0;
	int unsigned periph_last = 0;
	int unsigned audio_last = 0;
	int unsigned cpu_last = 0;
	logic        periph_valid = 1'b0;
	logic        audio_valid = 1'b0;
	logic        cpu_valid = 1'b0;
	logic        prev_sys = 1'b0;
	logic        prev_cpu = 1'b0;
	int unsigned sys_len = 0;
	int unsigned cpu_len = 0;
	int unsigned reset_lengths = 0;
	int unsigned periph_gaps = 0;
	int unsigned audio_gaps = 0;
	int unsigned cpu_gaps = 0;

	assign reset_wire = power_on_reset | pulse_reset;
	assign model_sys  = (sys_count != 0);
	assign model_cpu  = model_sys || (cpu_count != 0);

	tb_clock_gen tb_clock_gen_inst (
		.CLK_50M        (CLK_50M),
		.power_on_reset (power_on_reset)
	);

	pcxt_timing_top pcxt_timing_top_inst (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.speed_request (speed_request),
		.bus_done      (bus_done),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset),
		.cpu_tick      (cpu_tick),
		.periph_tick   (periph_tick),
		.audio_tick    (audio_tick),
		.cpu_speed     (cpu_speed),
		.turbo         (turbo)
	);

	//////////////////////////////////////////////////////////////////////
	// Rate arithmetic and speed rules
	//////////////////////////////////////////////////////////////////////

	function automatic int unsigned floor_gap(input logic [31:0] rate);
		return pcxt_timing_pkg::CLK_HZ / rate;
	endfunction

	function automatic int unsigned ceil_gap(input logic [31:0] rate);
		return (pcxt_timing_pkg::CLK_HZ + rate - 32'd1) / rate;
	endfunction

	function automatic logic [31:0] speed_rate(input pcxt_timing_pkg::cpu_speed_e speed);
		case (speed)
			pcxt_timing_pkg::SPEED_7M16: return pcxt_timing_pkg::TICK_RATE_HZ[1];
			pcxt_timing_pkg::SPEED_14M3: return pcxt_timing_pkg::TICK_RATE_HZ[2];
			default:                     return pcxt_timing_pkg::TICK_RATE_HZ[0];
		endcase
	endfunction

	// Unused code 3 runs at stock speed
	function automatic pcxt_timing_pkg::cpu_speed_e accepted_speed(
		input pcxt_timing_pkg::cpu_speed_e req);
		if (req == pcxt_timing_pkg::SPEED_7M16 || req == pcxt_timing_pkg::SPEED_14M3) begin
			return req;
		end else begin
			return pcxt_timing_pkg::SPEED_4M77;
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Failure reporting and compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Errors found");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_run($sformatf("[ERROR] %0t %s expected %b actual %b",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_speed(input string name,
		input pcxt_timing_pkg::cpu_speed_e expected, input pcxt_timing_pkg::cpu_speed_e actual);
		if (actual !== expected) begin
			stop_run($sformatf("[ERROR] %0t %s expected %0d actual %0d",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_gap(input string name, input int unsigned gap,
		input int unsigned lo, input int unsigned hi);
		if (gap < lo || gap > hi) begin
			stop_run($sformatf("[ERROR] %0t %s expected %0d..%0d actual %0d",
				$time, name, lo, hi, gap));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model, updated on the same edges as the DUT
	//////////////////////////////////////////////////////////////////////

	always @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			sys_count   <= SYS_CYCLES;
			cpu_count   <= CPU_CYCLES;
			model_speed <= pcxt_timing_pkg::SPEED_4M77;
		end else if (sys_count != 0) begin
			sys_count   <= sys_count - 1;
			model_speed <= pcxt_timing_pkg::SPEED_4M77;
		end else begin
			if (cpu_count != 0) begin
				cpu_count <= cpu_count - 1;
			end
			// Speed taken only at the end of a bus cycle
			if (bus_done) begin
				model_speed <= accepted_speed(speed_request);
			end
		end
	end

	// Random bus traffic, bus_done about one cycle in eight
	always @(posedge CLK_50M) begin
		bus_done      <= (($random(seed) & 7) == 0);
		speed_request <= pcxt_timing_pkg::cpu_speed_e'(2'($random(seed)));
	end

	//////////////////////////////////////////////////////////////////////
	// Output checks on the falling edge
	//////////////////////////////////////////////////////////////////////

	always @(negedge CLK_50M) begin
		cycle = cycle + 1;
		check_bit("sys_reset", model_sys, sys_reset);
		check_bit("cpu_reset", model_cpu, cpu_reset);
		check_speed("cpu_speed", model_speed, cpu_speed);
		check_bit("turbo", model_speed != pcxt_timing_pkg::SPEED_4M77, turbo);
		// Reset phase lengths counted from the reset_wire release
		if (reset_wire) begin
			sys_len = 0;
			cpu_len = 0;
		end else begin
			if (sys_reset) begin
				sys_len = sys_len + 1;
			end else if (cpu_reset) begin
				cpu_len = cpu_len + 1;
			end
			if (prev_sys && !sys_reset) begin
				check_gap("sys_reset length", sys_len, SYS_CYCLES, SYS_CYCLES);
				reset_lengths = reset_lengths + 1;
			end
			if (prev_cpu && !cpu_reset) begin
				check_gap("cpu_reset length", cpu_len, CPU_CYCLES, CPU_CYCLES);
				reset_lengths = reset_lengths + 1;
			end
		end
		prev_sys = sys_reset;
		prev_cpu = cpu_reset;
		if (model_sys) begin
			// All enables quiet during the system reset
			check_bit("cpu_tick", 1'b0, cpu_tick);
			check_bit("periph_tick", 1'b0, periph_tick);
			check_bit("audio_tick", 1'b0, audio_tick);
			periph_valid = 1'b0;
			audio_valid  = 1'b0;
			cpu_valid    = 1'b0;
		end else begin
			// Interval across a speed change is not checked
			if (model_speed != prev_speed) begin
				cpu_valid = 1'b0;
			end
			if (periph_tick) begin
				if (periph_valid) begin
					check_gap("periph_tick gap", cycle - periph_last,
						floor_gap(PERIPH_RATE), ceil_gap(PERIPH_RATE));
					periph_gaps = periph_gaps + 1;
				end
				periph_last  = cycle;
				periph_valid = 1'b1;
			end
			if (audio_tick) begin
				if (audio_valid) begin
					check_gap("audio_tick gap", cycle - audio_last,
						floor_gap(AUDIO_RATE), ceil_gap(AUDIO_RATE));
					audio_gaps = audio_gaps + 1;
				end
				audio_last  = cycle;
				audio_valid = 1'b1;
			end
			if (cpu_tick) begin
				if (cpu_valid) begin
					check_gap("cpu_tick gap", cycle - cpu_last,
						floor_gap(speed_rate(model_speed)), ceil_gap(speed_rate(model_speed)));
					cpu_gaps = cpu_gaps + 1;
				end
				cpu_last  = cycle;
				cpu_valid = 1'b1;
			end
		end
		prev_speed = model_speed;
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		@(negedge power_on_reset);
		// First reset sequence, then traffic
		repeat (SYS_CYCLES + CPU_CYCLES + STIM_CYCLES) @(posedge CLK_50M);
		// Mid-run pulse restarts the sequence
		pulse_reset <= 1'b1;
		repeat (PULSE_CYCLES) @(posedge CLK_50M);
		pulse_reset <= 1'b0;
		repeat (SYS_CYCLES + CPU_CYCLES + STIM_CYCLES) @(posedge CLK_50M);
		if (reset_lengths != 4 || periph_gaps == 0 || audio_gaps == 0 || cpu_gaps == 0) begin
			stop_run("Too few checks ran, reset lengths or tick gaps were never seen");
		end else begin
			$display("No errors");
			$finish;
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge CLK_50M);
		stop_run("Watchdog timeout, the run did not reach its end in time");
	end

endmodule

`default_nettype wire

/* flist.f */
common/pcxt_timing_pkg.sv
common/tick_if.sv
source/reset_sequencer.sv
clocking/rate_strobe.sv
clocking/cpu_clock_select.sv
source/pcxt_timing_top.sv
test/tb_clock_gen.sv
test/pcxt_timing_assert.sv
test/pcxt_timing_tb.sv

/* Makefile */
# Verilator build for the pcxt_timing testbench
TOP = pcxt_timing_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

# Exit status of the simulation binary is the pass or fail result
sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
